// File: verilog/ldStoPkg.sv
// Load/store unit package with word widths, console address map and store buffer sizing
`default_nettype none

package ldStoPkg;

    // ------------------------------------------------------------------
    // Datapath widths
    // ------------------------------------------------------------------
    localparam int dataWidth = 32;
    localparam int addrWidth = 32;

    // ------------------------------------------------------------------
    // Address map
    // ------------------------------------------------------------------
    // Console data register
    localparam logic [addrWidth-1:0] comAddr = 32'hFFFF_FF00;
    // Console write counter
    localparam logic [addrWidth-1:0] comStatAddr = 32'hFFFF_FF04;
    // Everything from here up is uncached, except the console pair
    localparam logic [addrWidth-1:0] nonCacheBase = 32'hF000_0000;

    // ------------------------------------------------------------------
    // Store buffer
    // ------------------------------------------------------------------
    localparam int storeBufDepth = 4;
    // Pointers wrap naturally, depth is a power of two
    localparam int storeBufPtrWidth = 2;

    // ------------------------------------------------------------------
    // Address kind, decoded when a request enters M
    // ------------------------------------------------------------------
    localparam logic [1:0] kindCache = 2'd0;
    localparam logic [1:0] kindNonCache = 2'd1;
    localparam logic [1:0] kindIo = 2'd2;

endpackage

`default_nettype wire

// File: verilog/ldStoPipe.sv
// Load/store pipeline with M and W stages, stall hold, squash and address decode
`timescale 1ns/100ps
`default_nettype none

module ldStoPipe
    import ldStoPkg::*;
(
    input  wire logic                 ioEnable_q1m,
    input  wire logic                 rst,
    // Request from the integer pipe
    input  wire logic                 memValid,
    input  wire logic                 isLoad,
    input  wire logic                 isStore,
    input  wire logic [addrWidth-1:0] addr,
    input  wire logic [dataWidth-1:0] storeData,
    input  wire logic                 stall,
    input  wire logic                 except,
    // M-stage lookup for load forwarding
    output logic      [addrWidth-1:0] mAddr,
    output logic                      mIsLoad,
    // W-stage fields
    output logic                      wValid,
    output logic                      wIsLoad,
    output logic                      wIsStore,
    output logic      [1:0]           wKind,
    output logic      [addrWidth-1:0] wAddr,
    output logic      [dataWidth-1:0] wData
);

    // M-stage state
    logic                 mValid;
    logic                 mLoad;
    logic                 mStore;
    logic [1:0]           mKind;
    logic [dataWidth-1:0] mData;

    // Map an address onto cacheable, uncached or console
    function automatic logic [1:0] decodeKind(input logic [addrWidth-1:0] a);
        logic [1:0] kind;
        if (a == comAddr || a == comStatAddr) begin
            kind = kindIo;
        end else if (a >= nonCacheBase) begin
            kind = kindNonCache;
        end else begin
            kind = kindCache;
        end
        return kind;
    endfunction

    // ------------------------------------------------------------------
    // M stage
    // ------------------------------------------------------------------
    // Accept on any unstalled edge, a bubble when memValid is low
    always_ff @(posedge ioEnable_q1m) begin
        if (rst) begin
            mValid <= 1'b0;
            mLoad  <= 1'b0;
            mStore <= 1'b0;
        end else if (!stall) begin
            mValid <= memValid;
            if (memValid) begin
                mLoad  <= isLoad;
                mStore <= isStore;
            end
        end
    end

    // Address, data and kind only follow a real request
    always_ff @(posedge ioEnable_q1m) begin
        if (!stall && memValid) begin
            mAddr <= addr;
            mData <= storeData;
            mKind <= decodeKind(addr);
        end
    end

    // Qualified for the store buffer compare
    assign mIsLoad = mValid & mLoad;

    // ------------------------------------------------------------------
    // W stage
    // ------------------------------------------------------------------
    // One pulse per surviving instruction
    // Low on squash, and low while stalled
    always_ff @(posedge ioEnable_q1m) begin
        if (rst) begin
            wValid   <= 1'b0;
            wIsLoad  <= 1'b0;
            wIsStore <= 1'b0;
        end else if (stall) begin
            wValid <= 1'b0;
        end else begin
            wValid <= mValid & ~except;
            if (mValid) begin
                wIsLoad  <= mLoad;
                wIsStore <= mStore;
            end
        end
    end

    always_ff @(posedge ioEnable_q1m) begin
        if (!stall && mValid) begin
            wKind <= mKind;
            wAddr <= mAddr;
            wData <= mData;
        end
    end

    // A request is a load or a store, never both
    reqOneOp: assert property (@(posedge ioEnable_q1m) disable iff (rst)
        memValid |-> !(isLoad && isStore));

endmodule

`default_nettype wire

// File: verilog/storeBuffer.sv
// Four-entry store buffer with cache drain, fast-store bypass and load forwarding
`timescale 1ns/100ps
`default_nettype none

module storeBuffer
    import ldStoPkg::*;
(
    input  wire logic                 ioEnable_q1m,
    input  wire logic                 rst,
    input  wire logic                 wValid,
    input  wire logic                 wIsStore,
    input  wire logic [1:0]           wKind,
    input  wire logic [addrWidth-1:0] wAddr,
    input  wire logic [dataWidth-1:0] wData,
    input  wire logic [addrWidth-1:0] mAddr,
    input  wire logic                 mIsLoad,
    input  wire logic                 cacheIdle,
    // Data cache write port
    output logic                      dcacheWrEn,
    output logic      [addrWidth-1:0] dcacheAddr,
    output logic      [dataWidth-1:0] dcacheData,
    output logic                      storeBufFull,
    // Forward result for the W cycle of the load
    output logic                      fwdHit,
    output logic      [dataWidth-1:0] fwdData
);

    // Entry storage
    logic [addrWidth-1:0]        addrMem [storeBufDepth];
    logic [dataWidth-1:0]        dataMem [storeBufDepth];
    logic [storeBufPtrWidth-1:0] wrPtr;
    logic [storeBufPtrWidth-1:0] rdPtr;
    logic [storeBufPtrWidth:0]   count;

    logic wStoreC;
    logic fastStore;
    logic enq;
    logic deq;

    // Forward lookup
    logic [storeBufPtrWidth-1:0] idx;
    logic                        hitNext;
    logic [dataWidth-1:0]        dataNext;

    // ------------------------------------------------------------------
    // Write-side control
    // ------------------------------------------------------------------
    assign wStoreC = wValid & wIsStore & (wKind == kindCache);
    // Straight to cache when nothing older is pending
    assign fastStore = wStoreC & (count == '0) & cacheIdle;
    assign enq = wStoreC & ~fastStore;
    // Drain oldest whenever the cache port is free
    assign deq = cacheIdle & ~fastStore & (count != '0);

    assign storeBufFull = (count == (storeBufPtrWidth + 1)'(storeBufDepth));

    // Cache port mux with the bypass ahead of the buffer
    assign dcacheWrEn = fastStore | deq;
    assign dcacheAddr = fastStore ? wAddr : addrMem[rdPtr];
    assign dcacheData = fastStore ? wData : dataMem[rdPtr];

    // ------------------------------------------------------------------
    // FIFO pointers and count
    // ------------------------------------------------------------------
    always_ff @(posedge ioEnable_q1m) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (enq) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (deq) begin
                rdPtr <= rdPtr + 1'b1;
            end
            count <= count + (enq ? 1'b1 : 1'b0) - (deq ? 1'b1 : 1'b0);
        end
    end

    always_ff @(posedge ioEnable_q1m) begin
        if (enq) begin
            addrMem[wrPtr] <= wAddr;
            dataMem[wrPtr] <= wData;
        end
    end

    // ------------------------------------------------------------------
    // Load forwarding
    // ------------------------------------------------------------------
    // Walk oldest to newest so the last match wins
    always_comb begin
        hitNext  = 1'b0;
        dataNext = '0;
        idx      = rdPtr;
        for (int i = 0; i < storeBufDepth; i++) begin
            idx = rdPtr + storeBufPtrWidth'(i);
            if ((storeBufPtrWidth + 1)'(i) < count &&
                addrMem[idx][addrWidth-1:2] == mAddr[addrWidth-1:2]) begin
                hitNext  = 1'b1;
                dataNext = dataMem[idx];
            end
        end
        // Store in W right now is newer than any entry
        if (wStoreC && wAddr[addrWidth-1:2] == mAddr[addrWidth-1:2]) begin
            hitNext  = 1'b1;
            dataNext = wData;
        end
        hitNext = hitNext & mIsLoad;
    end

    always_ff @(posedge ioEnable_q1m) begin
        if (rst) begin
            fwdHit <= 1'b0;
        end else begin
            fwdHit <= hitNext;
        end
    end

    always_ff @(posedge ioEnable_q1m) begin
        fwdData <= dataNext;
    end

    // Environment must stall the pipe while full
    noEnqFull: assert property (@(posedge ioEnable_q1m) disable iff (rst)
        enq |-> !storeBufFull);

    // A drain reads a written slot, so the pointers differ unless the buffer is full
    noDrainEmpty: assert property (@(posedge ioEnable_q1m) disable iff (rst)
        deq |-> (rdPtr != wrPtr || storeBufFull));

endmodule

`default_nettype wire

// File: verilog/ioPort.sv
// Console I/O port with a data register and a write counter
`timescale 1ns/100ps
`default_nettype none

module ioPort
    import ldStoPkg::*;
(
    input  wire logic                 ioEnable_q1m,
    input  wire logic                 rst,
    input  wire logic                 wValid,
    input  wire logic                 wIsLoad,
    input  wire logic                 wIsStore,
    input  wire logic [1:0]           wKind,
    input  wire logic [addrWidth-1:0] wAddr,
    input  wire logic [dataWidth-1:0] wData,
    // Console write side
    output logic                      ioWrStrobe,
    output logic      [dataWidth-1:0] ioData,
    // Read data for loadReturn
    output logic      [dataWidth-1:0] ioRdData
);

    logic                 ioWr;
    logic                 statClr;
    logic [dataWidth-1:0] ioDataReg;
    logic [dataWidth-1:0] wrCount;

    // Console store in W, either address
    assign ioWr = wValid & wIsStore & (wKind == kindIo);
    assign ioWrStrobe = ioWr & (wAddr == comAddr);
    assign statClr = ioWr & (wAddr == comStatAddr);

    // Show fresh data during the strobe, last value otherwise
    assign ioData = ioWrStrobe ? wData : ioDataReg;

    always_ff @(posedge ioEnable_q1m) begin
        if (ioWrStrobe) begin
            ioDataReg <= wData;
        end
    end

    // ------------------------------------------------------------------
    // Write counter
    // ------------------------------------------------------------------
    always_ff @(posedge ioEnable_q1m) begin
        if (rst) begin
            wrCount <= '0;
        end else if (statClr) begin
            wrCount <= '0;
        end else if (ioWrStrobe) begin
            wrCount <= wrCount + 1'b1;
        end
    end

    // Read mux, zero unless this is a load
    always_comb begin
        if (!wIsLoad) begin
            ioRdData = '0;
        end else if (wAddr == comStatAddr) begin
            ioRdData = wrCount;
        end else begin
            ioRdData = ioDataReg;
        end
    end

endmodule

`default_nettype wire

// File: verilog/loadReturn.sv
// Load return mux onto the memory bus plus the uncached write port
`timescale 1ns/100ps
`default_nettype none

module loadReturn
    import ldStoPkg::*;
(
    input  wire logic                 ioEnable_q1m,
    input  wire logic                 rst,
    input  wire logic                 wValid,
    input  wire logic                 wIsLoad,
    input  wire logic                 wIsStore,
    input  wire logic [1:0]           wKind,
    input  wire logic [dataWidth-1:0] wData,
    input  wire logic [dataWidth-1:0] cacheData,
    input  wire logic [dataWidth-1:0] sharedMemIn,
    input  wire logic                 fwdHit,
    input  wire logic [dataWidth-1:0] fwdData,
    input  wire logic [dataWidth-1:0] ioRdData,
    output logic      [dataWidth-1:0] memBus,
    output logic                      memBusValid,
    // Uncached write port
    output logic                      sharedMemWrEn,
    output logic      [dataWidth-1:0] sharedMemOut
);

    logic [dataWidth-1:0] loadSel;
    logic [dataWidth-1:0] memBusHold;

    // ------------------------------------------------------------------
    // Load data select
    // ------------------------------------------------------------------
    always_comb begin
        case (wKind)
            // Buffered store wins over stale cache line
            kindCache:    loadSel = fwdHit ? fwdData : cacheData;
            kindNonCache: loadSel = sharedMemIn;
            default:      loadSel = ioRdData;
        endcase
    end

    assign memBusValid = wValid & wIsLoad;
    assign memBus = memBusValid ? loadSel : memBusHold;

    // Keeps the bus steady between loads
    always_ff @(posedge ioEnable_q1m) begin
        if (rst) begin
            memBusHold <= '0;
        end else if (memBusValid) begin
            memBusHold <= loadSel;
        end
    end

    // Uncached store goes out in its W cycle
    assign sharedMemWrEn = wValid & wIsStore & (wKind == kindNonCache);
    assign sharedMemOut = wData;

    // Shared port carries either a load or a store, never both
    busOneDir: assert property (@(posedge ioEnable_q1m) disable iff (rst)
        !(memBusValid && sharedMemWrEn));

endmodule

`default_nettype wire

// File: verilog/ldStoDatapath.sv
// Load/store unit datapath top joining pipe, store buffer, console port and load return
`timescale 1ns/100ps
`default_nettype none

module ldStoDatapath
    import ldStoPkg::*;
(
    input  wire logic                 ioEnable_q1m,
    input  wire logic                 rst,
    // Request
    input  wire logic                 memValid,
    input  wire logic                 isLoad,
    input  wire logic                 isStore,
    input  wire logic [addrWidth-1:0] addr,
    input  wire logic [dataWidth-1:0] storeData,
    input  wire logic                 stall,
    input  wire logic                 except,
    // Cache and shared memory
    input  wire logic [dataWidth-1:0] cacheData,
    input  wire logic                 cacheIdle,
    input  wire logic [dataWidth-1:0] sharedMemIn,
    output logic      [dataWidth-1:0] memBus,
    output logic                      memBusValid,
    output logic                      dcacheWrEn,
    output logic      [addrWidth-1:0] dcacheAddr,
    output logic      [dataWidth-1:0] dcacheData,
    output logic                      sharedMemWrEn,
    output logic      [dataWidth-1:0] sharedMemOut,
    // Console
    output logic                      ioWrStrobe,
    output logic      [dataWidth-1:0] ioData,
    output logic                      storeBufFull
);

    // ------------------------------------------------------------------
    // Inter-block wires
    // ------------------------------------------------------------------
    logic [addrWidth-1:0] mAddr;
    logic                 mIsLoad;
    logic                 wValid;
    logic                 wIsLoad;
    logic                 wIsStore;
    logic [1:0]           wKind;
    logic [addrWidth-1:0] wAddr;
    logic [dataWidth-1:0] wData;
    logic                 fwdHit;
    logic [dataWidth-1:0] fwdData;
    logic [dataWidth-1:0] ioRdData;

    ldStoPipe i_ldStoPipe (
        .ioEnable_q1m, .rst,
        .memValid, .isLoad, .isStore, .addr, .storeData, .stall, .except,
        .mAddr, .mIsLoad,
        .wValid, .wIsLoad, .wIsStore, .wKind, .wAddr, .wData
    );

    storeBuffer i_storeBuffer (
        .ioEnable_q1m, .rst,
        .wValid, .wIsStore, .wKind, .wAddr, .wData,
        .mAddr, .mIsLoad, .cacheIdle,
        .dcacheWrEn, .dcacheAddr, .dcacheData, .storeBufFull,
        .fwdHit, .fwdData
    );

    ioPort i_ioPort (
        .ioEnable_q1m, .rst,
        .wValid, .wIsLoad, .wIsStore, .wKind, .wAddr, .wData,
        .ioWrStrobe, .ioData, .ioRdData
    );

    loadReturn i_loadReturn (
        .ioEnable_q1m, .rst,
        .wValid, .wIsLoad, .wIsStore, .wKind, .wData,
        .cacheData, .sharedMemIn, .fwdHit, .fwdData, .ioRdData,
        .memBus, .memBusValid, .sharedMemWrEn, .sharedMemOut
    );

endmodule

`default_nettype wire

// File: test/ldStoTb.sv
// Directed testbench for the load/store datapath with a cache model and store buffer reference
`timescale 1ns/100ps
`default_nettype none

module ldStoTb
    import ldStoPkg::*;
();

    // Upper bound on every wait loop, in cycles
    localparam int waitLimit = 64;

    logic                 ioEnable_q1m;
    logic                 rst;
    logic                 memValid;
    logic                 isLoad;
    logic                 isStore;
    logic [addrWidth-1:0] addr;
    logic [dataWidth-1:0] storeData;
    logic                 stall;
    logic                 except;
    logic [dataWidth-1:0] cacheData;
    logic                 cacheIdle;
    logic [dataWidth-1:0] sharedMemIn;
    logic [dataWidth-1:0] memBus;
    logic                 memBusValid;
    logic                 dcacheWrEn;
    logic [addrWidth-1:0] dcacheAddr;
    logic [dataWidth-1:0] dcacheData;
    logic                 sharedMemWrEn;
    logic [dataWidth-1:0] sharedMemOut;
    logic                 ioWrStrobe;
    logic [dataWidth-1:0] ioData;
    logic                 storeBufFull;

    // Bookkeeping
    int    errors;
    int    checks;
    string curTest;
    // Pending cache writes, {addr, data}, oldest first
    logic [63:0]          expCache [$];
    bit                   randIdle;
    bit                   idleLevel;
    logic [addrWidth-1:0] cacheM;

    ldStoDatapath i_ldStoDatapath (
        .ioEnable_q1m, .rst,
        .memValid, .isLoad, .isStore, .addr, .storeData, .stall, .except,
        .cacheData, .cacheIdle, .sharedMemIn,
        .memBus, .memBusValid, .dcacheWrEn, .dcacheAddr, .dcacheData,
        .sharedMemWrEn, .sharedMemOut, .ioWrStrobe, .ioData, .storeBufFull
    );

    always #4 ioEnable_q1m = ~ioEnable_q1m;

    // ------------------------------------------------------------------
    // Environment models
    // ------------------------------------------------------------------
    // Cache lookup follows the pipe: address caught in M, data shown in W
    always @(posedge ioEnable_q1m) begin
        if (!stall) begin
            if (memValid) begin
                cacheM <= addr;
            end
            cacheData <= ~cacheM;
        end
    end

    // Idle level, random or fixed
    always @(posedge ioEnable_q1m) begin
        if (randIdle) begin
            cacheIdle <= (($urandom & 32'd1) != 32'd0);
        end else begin
            cacheIdle <= idleLevel;
        end
    end

    // Every cache write must match the oldest pending store
    always @(negedge ioEnable_q1m) begin
        logic [63:0] front;
        if (!rst && dcacheWrEn) begin
            checks++;
            assert (expCache.size() != 0) else begin
                errors++;
                $display("Unexpected cache write to %h during %s", dcacheAddr, curTest);
            end
            if (expCache.size() != 0) begin
                front = expCache.pop_front();
                checkVal({curTest, " cache addr"}, front[63:32], dcacheAddr);
                checkVal({curTest, " cache data"}, front[31:0], dcacheData);
            end
        end
    end

    // ------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------
    task automatic checkVal(input string name, input logic [31:0] expVal,
                            input logic [31:0] actVal);
        checks++;
        assert (actVal === expVal) else begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, expVal, actVal);
        end
    endtask

    // Newest buffered store to the same word wins, else the cache pattern
    function automatic logic [31:0] predictLoad(input logic [31:0] a);
        logic [31:0] val;
        val = ~a;
        for (int i = 0; i < expCache.size(); i++) begin
            if (expCache[i][63:34] == a[31:2]) begin
                val = expCache[i][31:0];
            end
        end
        return val;
    endfunction

    task automatic setIdle(input bit rnd, input bit lvl);
        @(negedge ioEnable_q1m);
        randIdle  = rnd;
        idleLevel = lvl;
        @(posedge ioEnable_q1m);
    endtask

    // Returns on the accepting edge
    task automatic sendReq(input logic ld, input logic st, input logic [31:0] a,
                           input logic [31:0] d);
        @(posedge ioEnable_q1m);
        memValid  <= 1'b1;
        isLoad    <= ld;
        isStore   <= st;
        addr      <= a;
        storeData <= d;
        @(posedge ioEnable_q1m);
        memValid <= 1'b0;
        isLoad   <= 1'b0;
        isStore  <= 1'b0;
    endtask

    // Kinds: 0 load return, 1 uncached store, 2 console strobe, 3 cache write
    task automatic waitEvent(input int kind, input string name, input logic [31:0] expVal,
                             input int expLat);
        int          lat;
        bit          seen;
        logic [31:0] val;
        lat  = 0;
        seen = 1'b0;
        val  = '0;
        while (!seen && lat < waitLimit) begin
            @(negedge ioEnable_q1m);
            lat++;
            case (kind)
                0: begin
                    seen = memBusValid;
                    val  = memBus;
                end
                1: begin
                    seen = sharedMemWrEn;
                    val  = sharedMemOut;
                end
                2: begin
                    seen = ioWrStrobe;
                    val  = ioData;
                end
                default: begin
                    seen = dcacheWrEn;
                    val  = dcacheData;
                end
            endcase
        end
        checks++;
        assert (seen) else begin
            errors++;
            $display("Timeout in %s: the expected pulse never came", name);
        end
        if (seen) begin
            checkVal(name, expVal, val);
            checkVal({name, " latency"}, 32'(expLat), 32'(lat));
        end
    endtask

    task automatic waitFull();
        int n;
        n = 0;
        do begin
            @(negedge ioEnable_q1m);
            n++;
        end while (!storeBufFull && n < waitLimit);
        checks++;
        assert (storeBufFull) else begin
            errors++;
            $display("Timeout in %s: store buffer never reported full", curTest);
        end
    endtask

    // Polled on rising edges, away from the write monitor
    task automatic waitDrain();
        int n;
        n = 0;
        do begin
            @(posedge ioEnable_q1m);
            n++;
        end while (expCache.size() != 0 && n < waitLimit);
        checks++;
        assert (expCache.size() == 0) else begin
            errors++;
            $display("Timeout in %s: store buffer did not drain", curTest);
        end
    endtask

    // No W action of any kind for a number of cycles
    task automatic expectQuiet(input int cycles);
        repeat (cycles) begin
            @(negedge ioEnable_q1m);
            checks++;
            assert (!memBusValid && !sharedMemWrEn && !ioWrStrobe && !dcacheWrEn) else begin
                errors++;
                $display("%s: memory activity seen while none was due", curTest);
            end
        end
    endtask

    task automatic squashStore(input logic [31:0] a, input logic [31:0] d);
        sendReq(1'b0, 1'b1, a, d);
        except <= 1'b1;
        @(posedge ioEnable_q1m);
        except <= 1'b0;
        expectQuiet(4);
    endtask

    // ------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------
    task automatic testCacheLoad();
        logic [31:0] a;
        curTest = "testCacheLoad";
        setIdle(1'b1, 1'b1);
        waitDrain();
        for (int i = 0; i < 4; i++) begin
            a = 32'h0000_1000 + 32'(i) * 32'h0101_0104;
            sendReq(1'b1, 1'b0, a, '0);
            waitEvent(0, curTest, predictLoad(a), 2);
        end
    endtask

    task automatic testStoreDrain();
        logic [31:0] a;
        logic [31:0] d;
        curTest = "testStoreDrain";
        setIdle(1'b1, 1'b1);
        waitDrain();
        // Cache busy, so every store lands in the buffer
        setIdle(1'b0, 1'b0);
        for (int i = 0; i < storeBufDepth; i++) begin
            a = 32'h0000_2000 + 32'(i) * 32'h0000_0044;
            d = 32'hD000_0000 | (a << 4);
            expCache.push_back({a, d});
            sendReq(1'b0, 1'b1, a, d);
        end
        waitFull();
        @(posedge ioEnable_q1m);
        stall <= 1'b1;
        setIdle(1'b0, 1'b1);
        waitDrain();
        @(posedge ioEnable_q1m);
        stall <= 1'b0;
        @(negedge ioEnable_q1m);
        checkVal({curTest, " full after drain"}, 32'd0, {31'd0, storeBufFull});
        // Empty buffer, idle cache, write goes straight through
        expCache.push_back({32'h0000_3010, 32'hFA57_0001});
        sendReq(1'b0, 1'b1, 32'h0000_3010, 32'hFA57_0001);
        waitEvent(3, {curTest, " fast store"}, 32'hFA57_0001, 2);
    endtask

    task automatic testForward();
        logic [31:0] a;
        curTest = "testForward";
        setIdle(1'b1, 1'b1);
        waitDrain();
        setIdle(1'b0, 1'b0);
        a = 32'h0000_4020;
        expCache.push_back({a, 32'h1111_AAAA});
        sendReq(1'b0, 1'b1, a, 32'h1111_AAAA);
        expCache.push_back({a, 32'h2222_BBBB});
        sendReq(1'b0, 1'b1, a, 32'h2222_BBBB);
        sendReq(1'b1, 1'b0, a, '0);
        waitEvent(0, {curTest, " same word"}, predictLoad(a), 2);
        // Byte offset inside the word still hits
        sendReq(1'b1, 1'b0, a + 32'd2, '0);
        waitEvent(0, {curTest, " byte offset"}, predictLoad(a + 32'd2), 2);
        // Neighbouring word misses
        sendReq(1'b1, 1'b0, a + 32'd4, '0);
        waitEvent(0, {curTest, " next word"}, predictLoad(a + 32'd4), 2);
        setIdle(1'b1, 1'b1);
        waitDrain();
    endtask

    task automatic testNonCache();
        curTest = "testNonCache";
        setIdle(1'b1, 1'b1);
        sharedMemIn <= 32'h5EED_C0DE;
        sendReq(1'b0, 1'b1, nonCacheBase + 32'h40, 32'hCAFE_0001);
        waitEvent(1, {curTest, " store"}, 32'hCAFE_0001, 2);
        sendReq(1'b1, 1'b0, 32'hF100_0008, '0);
        waitEvent(0, {curTest, " load"}, 32'h5EED_C0DE, 2);
    endtask

    task automatic testConsole();
        logic [31:0] d;
        int          numStores;
        curTest   = "testConsole";
        numStores = 3;
        d         = '0;
        // Start the count from zero
        sendReq(1'b0, 1'b1, comStatAddr, '0);
        for (int i = 0; i < numStores; i++) begin
            d = 32'hC0DE_0000 + 32'(i) * 32'h11;
            sendReq(1'b0, 1'b1, comAddr, d);
            waitEvent(2, {curTest, " strobe"}, d, 2);
        end
        sendReq(1'b1, 1'b0, comAddr, '0);
        waitEvent(0, {curTest, " data"}, d, 2);
        sendReq(1'b1, 1'b0, comStatAddr, '0);
        waitEvent(0, {curTest, " count"}, 32'(numStores), 2);
        sendReq(1'b0, 1'b1, comStatAddr, '0);
        sendReq(1'b1, 1'b0, comStatAddr, '0);
        waitEvent(0, {curTest, " cleared"}, 32'd0, 2);
    endtask

    task automatic testStallExcept();
        logic [31:0] a;
        curTest = "testStallExcept";
        setIdle(1'b0, 1'b1);
        waitDrain();
        // Load held in M for a while
        a = 32'h0000_5008;
        sendReq(1'b1, 1'b0, a, '0);
        stall <= 1'b1;
        expectQuiet(5);
        @(posedge ioEnable_q1m);
        stall <= 1'b0;
        waitEvent(0, {curTest, " stalled load"}, predictLoad(a), 2);
        // Same for an uncached store
        sendReq(1'b0, 1'b1, 32'hF000_0100, 32'h57A1_1ED0);
        stall <= 1'b1;
        expectQuiet(4);
        @(posedge ioEnable_q1m);
        stall <= 1'b0;
        waitEvent(1, {curTest, " stalled store"}, 32'h57A1_1ED0, 2);
        // Squashed stores of each kind
        squashStore(32'h0000_6000, 32'hDEAD_0001);
        squashStore(32'hF000_0200, 32'hDEAD_0002);
        squashStore(comAddr, 32'hDEAD_0003);
    endtask

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------
    initial begin
        void'($urandom(32'h4a73_65e0));
        ioEnable_q1m = 1'b0;
        rst          = 1'b1;
        memValid     = 1'b0;
        isLoad       = 1'b0;
        isStore      = 1'b0;
        addr         = '0;
        storeData    = '0;
        stall        = 1'b0;
        except       = 1'b0;
        cacheData    = '0;
        cacheIdle    = 1'b0;
        sharedMemIn  = '0;
        randIdle     = 1'b0;
        idleLevel    = 1'b0;
        cacheM       = '0;
        errors       = 0;
        checks       = 0;
        curTest      = "reset";
        repeat (8) @(posedge ioEnable_q1m);
        rst <= 1'b0;
        @(negedge ioEnable_q1m);
        // Valid, write and full flags all low out of reset
        checkVal("reset outputs", 32'd0,
                 {27'd0, memBusValid, dcacheWrEn, sharedMemWrEn, ioWrStrobe, storeBufFull});
        testCacheLoad();
        testStoreDrain();
        testForward();
        testNonCache();
        testConsole();
        testStallExcept();
        repeat (4) @(posedge ioEnable_q1m);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
verilog/ldStoPkg.sv
verilog/ldStoPipe.sv
verilog/storeBuffer.sv
verilog/ioPort.sv
verilog/loadReturn.sv
verilog/ldStoDatapath.sv
test/ldStoTb.sv

// File: Makefile
# Verilator build and run for the load/store datapath testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --assert --timing -Wno-fatal --timescale 1ns/100ps \
		--top-module ldStoTb -f vlog.f -o ldStoSim
	./obj_dir/ldStoSim 2>&1 | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
